// File: ldpc_dec_checker.sv
/*
  protocol assertions on the decoder top level
  sop/eop framing, ordy/obusy exclusion, idle outputs after reset
*/

`timescale 1ns/1ps
`default_nettype none

module ldpc_dec_checker (
  input logic iclk,
  input logic rst,
  input logic ordy,
  input logic obusy,
  input logic ofull,
  input logic oval,
  input logic osop,
  input logic oeop
);

  // ----------------------------------------------------------------------
  // output framing
  // ----------------------------------------------------------------------
  sop_with_val: assert property (@(posedge iclk) disable iff (rst) osop |-> oval)
    else $error("osop seen without oval");

  // byte 1 always right behind byte 0
  eop_after_sop: assert property (@(posedge iclk) disable iff (rst) osop |=> oeop)
    else $error("oeop did not follow osop");

  // ----------------------------------------------------------------------
  // input flags and reset state
  // ----------------------------------------------------------------------
  rdy_busy_excl: assert property (@(posedge iclk) disable iff (rst) !(ordy && obusy))
    else $error("ordy and obusy high together");

  reset_idle: assert property (@(posedge iclk)
    $fell(rst) |-> ordy && !obusy && !ofull && !oval && !osop && !oeop)
    else $error("outputs not idle after reset");

endmodule

bind ldpc_dec_top ldpc_dec_checker checker_inst (
  .iclk, .rst, .ordy, .obusy, .ofull, .oval, .osop, .oeop
);

`default_nettype wire

// File: ldpc_dec_engine.sv
/*
  decoding engine
  hard decisions, row/column parity accumulation,
  single-crossing correction, result write to output buffer
*/

`timescale 1ns/1ps
`default_nettype none

`include "ldpc_mini_dec_macros.svh"

module ldpc_dec_engine import ldpc_mini_dec_pkg::*; (
  input  logic                          iclk,
  input  logic                          rst,
  // input buffer
  input  logic                          in_full,
  output logic [`LDPC_ADDR_W-1:0]       in_addr,
  input  logic signed [`LDPC_LLR_W-1:0] in_llr,
  input  logic [`LDPC_TAG_W-1:0]        in_tag,
  output logic                          in_release,
  // output buffer
  input  logic                          out_full,
  output logic                          out_wr,
  output logic [2*`LDPC_BYTE_W-1:0]     out_bytes,
  output dec_status_t                   out_status
);

  engine_state_t             state;
  logic [`LDPC_ADDR_W-1:0]   cnt;
  // read pipeline, sample index of the data now on in_llr
  logic                      rd_vld;
  logic [`LDPC_ADDR_W-1:0]   rd_idx;
  logic [`LDPC_FRAME_LEN-1:0] hard;
  logic [`LDPC_FRAME_LEN-1:0] hard_nxt;
  logic [`LDPC_SIDE-1:0]     row_par;
  logic [`LDPC_SIDE-1:0]     col_par;
  logic [`LDPC_SIDE-1:0]     row_nxt;
  logic [`LDPC_SIDE-1:0]     col_nxt;
  logic [`LDPC_FRAME_LEN-1:0] flip;
  logic                      row_one;
  logic                      col_one;

  // ----------------------------------------------------------------------
  // FSM, 16 reads + correct + write
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (rst) begin
      state  <= E_IDLE;
      cnt    <= '0;
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= (state == E_READ);
      case (state)
        E_IDLE: begin
          // need a full input bank and somewhere to put the result
          if (in_full && !out_full) begin
            state <= E_READ;
            cnt   <= '0;
          end
        end
        E_READ: begin
          cnt <= cnt + 1'b1;
          if (cnt == `LDPC_ADDR_W'(`LDPC_FRAME_LEN - 1)) begin
            state <= E_CORRECT;
          end
        end
        E_CORRECT: state <= E_WRITE;
        E_WRITE:   state <= E_IDLE;
        default:   state <= E_IDLE;
      endcase
    end
  end

  assign in_addr = cnt;

  // ----------------------------------------------------------------------
  // hard decision and parity accumulation
  // ----------------------------------------------------------------------
  always_comb begin
    hard_nxt = hard;
    row_nxt  = row_par;
    col_nxt  = col_par;
    if (rd_vld) begin
      // negative llr -> 1
      hard_nxt[rd_idx] = in_llr[`LDPC_LLR_W-1];
      row_nxt[rd_idx / `LDPC_SIDE] = row_par[rd_idx / `LDPC_SIDE] ^ in_llr[`LDPC_LLR_W-1];
      col_nxt[rd_idx % `LDPC_SIDE] = col_par[rd_idx % `LDPC_SIDE] ^ in_llr[`LDPC_LLR_W-1];
    end
  end

  always_ff @(posedge iclk) begin
    rd_idx <= cnt;
    // cleared between frames
    if (state == E_IDLE) begin
      hard    <= '0;
      row_par <= '0;
      col_par <= '0;
    end else begin
      hard    <= hard_nxt;
      row_par <= row_nxt;
      col_par <= col_nxt;
    end
  end

  // crossing of failed row and failed column
  always_comb begin
    for (int k = 0; k < `LDPC_FRAME_LEN; k++) begin
      flip[k] = row_nxt[k / `LDPC_SIDE] & col_nxt[k % `LDPC_SIDE];
    end
  end

  // exactly one bit set
  assign row_one = (row_nxt != '0) && ((row_nxt & (row_nxt - 1'b1)) == '0);
  assign col_one = (col_nxt != '0) && ((col_nxt & (col_nxt - 1'b1)) == '0);

  // ----------------------------------------------------------------------
  // correction, last sample arrives during CORRECT
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (state == E_CORRECT) begin
      out_status.tag <= in_tag;
      if (row_nxt == '0 && col_nxt == '0) begin
        out_bytes          <= hard_nxt;
        out_status.decfail <= 1'b0;
        out_status.err     <= '0;
      end else if (row_one && col_one) begin
        // single error, flip the crossing bit
        out_bytes          <= hard_nxt ^ flip;
        out_status.decfail <= 1'b0;
        out_status.err     <= {{(`LDPC_ERR_W-1){1'b0}}, 1'b1};
      end else begin
        // uncorrectable, raw decisions out
        out_bytes          <= hard_nxt;
        out_status.decfail <= 1'b1;
        out_status.err     <= '0;
      end
    end
  end

  assign out_wr     = (state == E_WRITE);
  assign in_release = (state == E_WRITE);

endmodule

`default_nettype wire

// File: ldpc_dec_pingpong_buf.sv
/*
  two-bank ping-pong frame buffer
  word write port with set-full, registered read port with release,
  per-bank full flag and tag
*/

`timescale 1ns/1ps
`default_nettype none

`include "ldpc_mini_dec_macros.svh"

module ldpc_dec_pingpong_buf #(
  parameter int  DATA_W = 8,
  parameter int  DEPTH  = 16,
  parameter int  TAG_W  = 4,
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic              iclk,
  input  logic              rst,
  // write side
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  logic [DATA_W-1:0] wr_data,
  input  logic              wr_set_full,
  input  logic [TAG_W-1:0]  wr_tag,
  // read side
  input  logic [ADDR_W-1:0] rd_addr,
  input  logic              rd_release,
  output logic [DATA_W-1:0] rd_data,
  output logic [TAG_W-1:0]  rd_tag,
  // flags
  output logic              wr_full,
  output logic              rd_full
);

  logic [DATA_W-1:0]      mem  [`LDPC_BANKS][DEPTH];
  logic [TAG_W-1:0]       tags [`LDPC_BANKS];
  logic [`LDPC_BANKS-1:0] full;
  // bank pointers, each side walks the banks in the same order
  logic                   wr_ptr;
  logic                   rd_ptr;

  // ----------------------------------------------------------------------
  // bank flags and pointers
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (rst) begin
      full   <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      // set and release never hit the same bank
      if (wr_set_full) begin
        full[wr_ptr] <= 1'b1;
        wr_ptr       <= ~wr_ptr;
      end
      if (rd_release) begin
        full[rd_ptr] <= 1'b0;
        rd_ptr       <= ~rd_ptr;
      end
    end
  end

  // ----------------------------------------------------------------------
  // storage, read data one cycle after address
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (wr_en) begin
      mem[wr_ptr][wr_addr] <= wr_data;
    end
    if (wr_set_full) begin
      tags[wr_ptr] <= wr_tag;
    end
    rd_data <= mem[rd_ptr][rd_addr];
    rd_tag  <= tags[rd_ptr];
  end

  assign wr_full = full[wr_ptr];
  assign rd_full = full[rd_ptr];

endmodule

`default_nettype wire

// File: ldpc_dec_sink.sv
/*
  output sink
  ireq/ofull handshake, two-byte read-out with sop/eop and status
*/

`timescale 1ns/1ps
`default_nettype none

`include "ldpc_mini_dec_macros.svh"

module ldpc_dec_sink import ldpc_mini_dec_pkg::*; (
  input  logic                      iclk,
  input  logic                      rst,
  input  logic                      ireq,
  // output buffer
  input  logic                      buf_full,
  input  logic [2*`LDPC_BYTE_W-1:0] buf_bytes,
  input  dec_status_t               buf_status,
  output logic                      buf_release,
  // external
  output logic                      ofull,
  output logic                      oval,
  output logic                      osop,
  output logic                      oeop,
  output logic [`LDPC_BYTE_W-1:0]   odat,
  output logic [`LDPC_TAG_W-1:0]    otag,
  output logic                      odecfail,
  output logic [`LDPC_ERR_W-1:0]    oerr
);

  sink_state_t state;

  // ----------------------------------------------------------------------
  // FSM, request taken only when idle with a frame waiting
  // ----------------------------------------------------------------------
  always_ff @(posedge iclk) begin
    if (rst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (ireq && buf_full) begin
            state <= S_BYTE0;
          end
        end
        S_BYTE0: state <= S_BYTE1;
        S_BYTE1: state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  assign ofull       = buf_full;
  // bank freed with the last byte
  assign buf_release = (state == S_BYTE1);

  assign oval = (state != S_IDLE);
  assign osop = (state == S_BYTE0);
  assign oeop = (state == S_BYTE1);
  // low byte first, lower sample in lower bit
  assign odat = (state == S_BYTE1) ? buf_bytes[2*`LDPC_BYTE_W-1:`LDPC_BYTE_W]
                                   : buf_bytes[`LDPC_BYTE_W-1:0];

  // status stays put while the bank is held
  assign otag     = buf_status.tag;
  assign odecfail = buf_status.decfail;
  assign oerr     = buf_status.err;

endmodule

`default_nettype wire

// File: ldpc_dec_source.sv
/*
  input source
  frame acceptance, sample addressing, tag capture, ordy/obusy
*/

`timescale 1ns/1ps
`default_nettype none

`include "ldpc_mini_dec_macros.svh"

module ldpc_dec_source (
  input  logic                          iclk,
  input  logic                          rst,
  input  logic                          ival,
  input  logic                          isop,
  input  logic                          ieop,
  input  logic [`LDPC_TAG_W-1:0]        itag,
  input  logic signed [`LDPC_LLR_W-1:0] illr,
  // write bank occupied
  input  logic                          buf_full,
  output logic                          ordy,
  output logic                          obusy,
  output logic                          wr_en,
  output logic                          wr_set_full,
  output logic [`LDPC_ADDR_W-1:0]       wr_addr,
  output logic signed [`LDPC_LLR_W-1:0] wr_llr,
  output logic [`LDPC_TAG_W-1:0]        wr_tag
);

  logic                    in_frame;
  logic [`LDPC_ADDR_W-1:0] cnt;
  logic [`LDPC_TAG_W-1:0]  tag_q;
  logic                    start;
  logic                    frame_end;

  // new frame only into a free bank
  assign ordy  = ~in_frame & ~buf_full;
  assign obusy = in_frame;
  assign start = ival & isop & ordy;

  assign wr_en   = start | (ival & in_frame);
  assign wr_addr = start ? '0 : cnt;
  assign wr_llr  = illr;

  // close on ieop, or once the bank holds a whole frame
  assign frame_end   = ieop | (wr_addr == `LDPC_ADDR_W'(`LDPC_FRAME_LEN - 1));
  assign wr_set_full = wr_en & frame_end;
  assign wr_tag      = start ? itag : tag_q;

  always_ff @(posedge iclk) begin
    if (rst) begin
      in_frame <= 1'b0;
      cnt      <= '0;
    end else if (wr_en) begin
      in_frame <= ~frame_end;
      cnt      <= wr_addr + 1'b1;
    end
  end

  // tag taken with isop
  always_ff @(posedge iclk) begin
    if (start) begin
      tag_q <= itag;
    end
  end

endmodule

`default_nettype wire

// File: ldpc_dec_top.sv
/*
  decoder top level
  source -> input ping-pong -> engine -> output ping-pong -> sink
*/

`timescale 1ns/1ps
`default_nettype none

`include "ldpc_mini_dec_macros.svh"

module ldpc_dec_top import ldpc_mini_dec_pkg::*; (
  input  logic                          iclk,
  input  logic                          rst,
  input  logic                          ival,
  input  logic                          isop,
  input  logic                          ieop,
  input  logic [`LDPC_TAG_W-1:0]        itag,
  input  logic signed [`LDPC_LLR_W-1:0] illr,
  output logic                          ordy,
  output logic                          obusy,
  input  logic                          ireq,
  output logic                          ofull,
  output logic                          oval,
  output logic                          osop,
  output logic                          oeop,
  output logic [`LDPC_TAG_W-1:0]        otag,
  output logic [`LDPC_BYTE_W-1:0]       odat,
  output logic                          odecfail,
  output logic [`LDPC_ERR_W-1:0]        oerr
);

  // source -> input buffer
  logic                          src_wr_en;
  logic                          src_set_full;
  logic [`LDPC_ADDR_W-1:0]       src_addr;
  logic signed [`LDPC_LLR_W-1:0] src_llr;
  logic [`LDPC_TAG_W-1:0]        src_tag;
  logic                          ibuf_wr_full;
  // input buffer -> engine
  logic                          ibuf_rd_full;
  logic signed [`LDPC_LLR_W-1:0] ibuf_llr;
  logic [`LDPC_TAG_W-1:0]        ibuf_tag;
  logic [`LDPC_ADDR_W-1:0]       eng_addr;
  logic                          eng_release;
  // engine -> output buffer
  logic                          eng_wr;
  logic [2*`LDPC_BYTE_W-1:0]     eng_bytes;
  dec_status_t                   eng_status;
  logic                          obuf_wr_full;
  // output buffer -> sink
  logic                          obuf_rd_full;
  logic [2*`LDPC_BYTE_W-1:0]     obuf_bytes;
  dec_status_t                   obuf_status;
  logic                          snk_release;

  // ----------------------------------------------------------------------
  // input side
  // ----------------------------------------------------------------------
  ldpc_dec_source source_inst (
    .iclk, .rst, .ival, .isop, .ieop, .itag, .illr,
    .buf_full    (ibuf_wr_full),
    .ordy, .obusy,
    .wr_en       (src_wr_en),
    .wr_set_full (src_set_full),
    .wr_addr     (src_addr),
    .wr_llr      (src_llr),
    .wr_tag      (src_tag)
  );

  ldpc_dec_pingpong_buf #(
    .DATA_W (`LDPC_LLR_W),
    .DEPTH  (`LDPC_FRAME_LEN),
    .TAG_W  (`LDPC_TAG_W)
  ) ibuf_inst (
    .iclk, .rst,
    .wr_en   (src_wr_en),    .wr_addr (src_addr),   .wr_data     (src_llr),
    .wr_set_full (src_set_full), .wr_tag (src_tag),
    .rd_addr (eng_addr),     .rd_release (eng_release),
    .rd_data (ibuf_llr),     .rd_tag  (ibuf_tag),
    .wr_full (ibuf_wr_full), .rd_full (ibuf_rd_full)
  );

  // ----------------------------------------------------------------------
  // engine
  // ----------------------------------------------------------------------
  ldpc_dec_engine engine_inst (
    .iclk, .rst,
    .in_full   (ibuf_rd_full), .in_addr (eng_addr),  .in_llr     (ibuf_llr),
    .in_tag    (ibuf_tag),     .in_release (eng_release),
    .out_full  (obuf_wr_full), .out_wr  (eng_wr),
    .out_bytes (eng_bytes),    .out_status (eng_status)
  );

  // ----------------------------------------------------------------------
  // output side, one word per bank
  // ----------------------------------------------------------------------
  ldpc_dec_pingpong_buf #(
    .DATA_W (2*`LDPC_BYTE_W),
    .DEPTH  (1),
    .TAG_W  ($bits(dec_status_t))
  ) obuf_inst (
    .iclk, .rst,
    .wr_en   (eng_wr),       .wr_addr (1'b0),       .wr_data     (eng_bytes),
    .wr_set_full (eng_wr),   .wr_tag  (eng_status),
    .rd_addr (1'b0),         .rd_release (snk_release),
    .rd_data (obuf_bytes),   .rd_tag  (obuf_status),
    .wr_full (obuf_wr_full), .rd_full (obuf_rd_full)
  );

  ldpc_dec_sink sink_inst (
    .iclk, .rst, .ireq,
    .buf_full    (obuf_rd_full),
    .buf_bytes   (obuf_bytes),
    .buf_status  (obuf_status),
    .buf_release (snk_release),
    .ofull, .oval, .osop, .oeop, .odat, .otag, .odecfail, .oerr
  );

endmodule

`default_nettype wire

// File: ldpc_mini_dec.f
+incdir+.
ldpc_mini_dec_pkg.sv
ldpc_dec_pingpong_buf.sv
ldpc_dec_source.sv
ldpc_dec_engine.sv
ldpc_dec_sink.sv
ldpc_dec_top.sv
ldpc_dec_checker.sv
tb_ldpc_dec.sv

// File: ldpc_mini_dec_macros.svh
/*
  frame decoder constants
  frame length, array side, llr/tag/err/byte widths,
  sample address width and ping-pong bank count
*/

`ifndef LDPC_MINI_DEC_MACROS_SVH
`define LDPC_MINI_DEC_MACROS_SVH

// samples per frame, laid out as a square bit array
`define LDPC_FRAME_LEN 16
`define LDPC_SIDE      4

// datapath widths
`define LDPC_LLR_W     8
`define LDPC_TAG_W     4
`define LDPC_ERR_W     4
`define LDPC_BYTE_W    8
`define LDPC_ADDR_W    4

// ping-pong depth, pointers are one bit
`define LDPC_BANKS     2

`endif

// File: ldpc_mini_dec_pkg.sv
/*
  shared decoder types
  per-frame status struct, engine and sink FSM states
*/

`default_nettype none

`include "ldpc_mini_dec_macros.svh"

package ldpc_mini_dec_pkg;

  // result of one frame, carried engine -> output buffer -> sink
  typedef struct packed {
    logic [`LDPC_TAG_W-1:0] tag;
    logic                   decfail;
    logic [`LDPC_ERR_W-1:0] err;
  } dec_status_t;

  // engine: idle, 16 reads, correction, write
  typedef enum logic [1:0] {E_IDLE, E_READ, E_CORRECT, E_WRITE} engine_state_t;

  // sink: idle, low byte, high byte
  typedef enum logic [1:0] {S_IDLE, S_BYTE0, S_BYTE1} sink_state_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the frame decoder testbench with verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f ldpc_mini_dec.f --top-module tb_ldpc_dec -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_ldpc_dec
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

// File: tb_ldpc_dec.sv
/*
  frame decoder testbench
  clock, reset, lfsr, reference model, watchdog,
  directed tests for clean, corrected, failed and back-pressured frames
*/

`timescale 1ns/1ps
`default_nettype none

`include "ldpc_mini_dec_macros.svh"

module tb_ldpc_dec import ldpc_mini_dec_pkg::*; ();

  localparam int PERIOD   = 40;
  localparam int FRAMES   = 7;
  localparam int WAIT_MAX = 100;

  typedef logic [`LDPC_FRAME_LEN*`LDPC_LLR_W-1:0] frame_t;

  logic                          iclk;
  logic                          rst;
  logic                          ival;
  logic                          isop;
  logic                          ieop;
  logic [`LDPC_TAG_W-1:0]        itag;
  logic signed [`LDPC_LLR_W-1:0] illr;
  logic                          ordy;
  logic                          obusy;
  logic                          ireq;
  logic                          ofull;
  logic                          oval;
  logic                          osop;
  logic                          oeop;
  logic [`LDPC_TAG_W-1:0]        otag;
  logic [`LDPC_BYTE_W-1:0]       odat;
  logic                          odecfail;
  logic [`LDPC_ERR_W-1:0]        oerr;
  logic [15:0]                   lfsr;

  ldpc_dec_top ldpc_dec_top_inst (
    .iclk, .rst, .ival, .isop, .ieop, .itag, .illr, .ordy, .obusy,
    .ireq, .ofull, .oval, .osop, .oeop, .otag, .odat, .odecfail, .oerr
  );

  initial begin
    iclk = 1'b0;
    forever #(PERIOD/2) iclk = ~iclk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp) else begin
      stop_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // fibonacci lfsr x^16+x^14+x^13+x^11+1, one step per bit
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r    = {r[6:0], lfsr[0]};
    end
    return r;
  endfunction

  // random 3x3 data block, row parity in column 3, column parity in row 3
  function automatic logic [15:0] make_codeword();
    logic [15:0] cw;
    logic [7:0]  b;
    cw = '0;
    for (int k = 0; k < 16; k++) begin
      if (k / 4 < 3 && k % 4 < 3) begin
        b     = rand_bits(1);
        cw[k] = b[0];
      end
    end
    for (int r = 0; r < 3; r++) begin
      cw[r*4+3] = ^cw[r*4 +: 3];
    end
    for (int c = 0; c < 4; c++) begin
      cw[12+c] = cw[c] ^ cw[4+c] ^ cw[8+c];
    end
    return cw;
  endfunction

  // bit 1 -> negative llr, magnitude 1..64
  function automatic frame_t to_llrs(input logic [15:0] bits);
    frame_t     f;
    logic [7:0] mag;
    for (int k = 0; k < 16; k++) begin
      mag          = rand_bits(6) + 8'd1;
      f[k*8 +: 8] = bits[k] ? -mag : mag;
    end
    return f;
  endfunction

  function automatic frame_t flip_sign(input frame_t f, input logic [3:0] pos);
    frame_t r;
    r = f;
    r[pos*8 +: 8] = -f[pos*8 +: 8];
    return r;
  endfunction

  function automatic logic [15:0] hard_bits(input frame_t f);
    logic [15:0] h;
    for (int k = 0; k < 16; k++) begin
      h[k] = f[k*8+7];
    end
    return h;
  endfunction

  // reference model, single row/column crossing gets corrected
  task automatic predict(input frame_t f, input logic [3:0] tag,
                         output logic [15:0] data, output dec_status_t st);
    logic [15:0] h;
    logic [3:0]  rf;
    logic [3:0]  cf;
    int          nr;
    int          nc;
    int          fr;
    int          fc;
    h  = hard_bits(f);
    rf = '0;
    cf = '0;
    nr = 0;
    nc = 0;
    fr = 0;
    fc = 0;
    for (int k = 0; k < 16; k++) begin
      rf[k/4] ^= h[k];
      cf[k%4] ^= h[k];
    end
    for (int i = 0; i < 4; i++) begin
      if (rf[i]) begin
        nr++;
        fr = i;
      end
      if (cf[i]) begin
        nc++;
        fc = i;
      end
    end
    data = h;
    st   = {tag, 1'b0, 4'd0};
    if (nr == 1 && nc == 1) begin
      data[fr*4+fc] = ~h[fr*4+fc];
      st.err        = 4'd1;
    end else if (nr != 0 || nc != 0) begin
      st.decfail = 1'b1;
    end
  endtask

  // ----------------------------------------------------------------------
  // bus tasks, entered and left just after a falling edge
  // ----------------------------------------------------------------------
  task automatic send_frame(input frame_t f, input logic [3:0] tag);
    int n;
    n = 0;
    while (ordy !== 1'b1) begin
      @(negedge iclk);
      n++;
      if (n > WAIT_MAX) stop_run("ordy stayed low, frame could not be sent");
    end
    for (int k = 0; k < 16; k++) begin
      // busy from the sample after isop on
      check_value("obusy", 16'(obusy), 16'(k != 0));
      ival = 1'b1;
      isop = (k == 0);
      ieop = (k == 15);
      itag = tag;
      illr = f[k*8 +: 8];
      @(negedge iclk);
    end
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
    // busy drops once ieop is taken
    check_value("obusy", 16'(obusy), 16'd0);
  endtask

  task automatic read_frame(input logic [15:0] exp_data, input dec_status_t exp_st);
    int n;
    n = 0;
    while (ofull !== 1'b1) begin
      @(negedge iclk);
      n++;
      if (n > WAIT_MAX) stop_run("ofull never came up for a decoded frame");
    end
    ireq = 1'b1;
    @(negedge iclk);
    ireq = 1'b0;
    assert (oval === 1'b1 && osop === 1'b1) else stop_run("no osop after ireq");
    check_value("odat", 16'(odat), 16'(exp_data[7:0]));
    check_value("otag", 16'(otag), 16'(exp_st.tag));
    check_value("odecfail", 16'(odecfail), 16'(exp_st.decfail));
    check_value("oerr", 16'(oerr), 16'(exp_st.err));
    @(negedge iclk);
    assert (oval === 1'b1 && oeop === 1'b1 && osop === 1'b0)
      else stop_run("second byte not marked with oeop");
    check_value("odat", 16'(odat), 16'(exp_data[15:8]));
    // status held over both bytes
    check_value("otag", 16'(otag), 16'(exp_st.tag));
    check_value("odecfail", 16'(odecfail), 16'(exp_st.decfail));
    check_value("oerr", 16'(oerr), 16'(exp_st.err));
    @(negedge iclk);
    assert (oval === 1'b0) else stop_run("oval still high after the last byte");
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset_values();
    assert (ordy === 1'b1) else stop_run("ordy low after reset");
    assert (obusy === 1'b0) else stop_run("obusy high after reset");
    assert (ofull === 1'b0 && oval === 1'b0) else stop_run("ofull or oval high after reset");
  endtask

  task automatic test_clean_frame();
    logic [15:0] cw;
    logic [3:0]  tag;
    cw  = make_codeword();
    tag = 4'(rand_bits(4));
    send_frame(to_llrs(cw), tag);
    read_frame(cw, {tag, 1'b0, 4'd0});
  endtask

  task automatic test_single_flip();
    logic [15:0] cw;
    logic [3:0]  tag;
    logic [3:0]  pos;
    cw  = make_codeword();
    tag = 4'(rand_bits(4));
    pos = 4'(rand_bits(4));
    send_frame(flip_sign(to_llrs(cw), pos), tag);
    read_frame(cw, {tag, 1'b0, 4'd1});
  endtask

  task automatic test_double_flip();
    frame_t     f;
    logic [3:0] tag;
    logic [3:0] p1;
    logic [3:0] p2;
    tag = 4'(rand_bits(4));
    p1  = 4'(rand_bits(4));
    p2  = 4'(rand_bits(4));
    // row in [3:2], column in [1:0]
    while (p2[3:2] == p1[3:2] || p2[1:0] == p1[1:0]) begin
      p2 = 4'(rand_bits(4));
    end
    f = flip_sign(flip_sign(to_llrs(make_codeword()), p1), p2);
    send_frame(f, tag);
    read_frame(hard_bits(f), {tag, 1'b1, 4'd0});
  endtask

  task automatic test_backpressure();
    logic [15:0] data_q[$];
    dec_status_t st_q[$];
    logic [15:0] data;
    dec_status_t st;
    frame_t      f;
    logic [3:0]  tag0;
    tag0 = 4'(rand_bits(4));
    // clean, one flip, two flips, clean
    for (int i = 0; i < 4; i++) begin
      f = to_llrs(make_codeword());
      if (i == 1 || i == 2) f = flip_sign(f, 4'(rand_bits(4)));
      if (i == 2) f = flip_sign(f, 4'(rand_bits(4)));
      predict(f, tag0 + 4'(i), data, st);
      data_q.push_back(data);
      st_q.push_back(st);
      send_frame(f, tag0 + 4'(i));
    end
    // both input and both output banks now occupied
    repeat (40) begin
      assert (ordy === 1'b0) else stop_run("ordy high while four frames are held");
      @(negedge iclk);
    end
    for (int i = 0; i < 4; i++) begin
      read_frame(data_q.pop_front(), st_q.pop_front());
    end
  endtask

  // ----------------------------------------------------------------------
  // watchdog and main sequence
  // ----------------------------------------------------------------------
  initial begin
    #(FRAMES * 80 * PERIOD + 100 * PERIOD);
    stop_run("watchdog timeout, tests did not finish in time");
  end

  initial begin
    lfsr = 16'd76;
    rst  = 1'b1;
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
    itag = '0;
    illr = '0;
    ireq = 1'b0;
    repeat (5) @(posedge iclk);
    @(negedge iclk);
    rst = 1'b0;
    @(negedge iclk);
    test_reset_values();
    test_clean_frame();
    test_single_flip();
    test_double_flip();
    test_backpressure();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
